/* files.f */
hw/mem_pkg.sv
hw/byte_lane.sv
hw/sram_seq.sv
hw/sram_pins.sv
hw/s3board_mem.sv
verification/ram_256kx16_model.sv
verification/tb_s3board_mem.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_s3board_mem
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* verification/tb_s3board_mem.sv */
`timescale 1ns/1ps
/*
 * Testbench for the board SRAM controller with two chip models.
 * Shadow memory reference, latency and read data checks, and a watchdog.
 */
module tb_s3board_mem;

   localparam int half = mem_pkg::data_bits / 2;
   localparam int reset_cycles = 5;
   localparam int total_reqs = 323;  // 23 directed requests and 300 random ones.
   localparam int timeout_cycles =
      2 * (total_reqs * (mem_pkg::seq_cycles + 2) + reset_cycles);

   logic clk = 1'b0;
   logic reset, req, we, byte_en, busy, done, ram_we_n, ram_oe_n;
   logic ram1_ce_n, ram1_ub_n, ram1_lb_n, ram1_dout_en;
   logic ram2_ce_n, ram2_ub_n, ram2_lb_n, ram2_dout_en;
   logic [mem_pkg::addr_bits-1:0] addr, base, a0;
   logic [mem_pkg::data_bits-1:0] wdata, rdata, ram1_dout, ram1_din, ram2_dout, ram2_din;
   logic [mem_pkg::ram_addr_bits-1:0] ram_a;
   logic [mem_pkg::addr_bits-1:0] word_addrs [6] =
      '{20'h00000, 20'h00002, 20'h3fffe, 20'h80000, 20'h8a5c6, 20'hffffe};
   logic [half-1:0] shadow [logic [mem_pkg::addr_bits-1:0]];
   logic [mem_pkg::data_bits-1:0] pend_exp [$];
   int pend_cycle [$];
   bit pend_read [$];
   int cycle_count = 0;
   int pass_count = 0;
   int fail_count = 0;
   int errors_before = 0;
   int age;
   logic [31:0] r;

   always #2 clk = ~clk;  // 4 ns period.

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   s3board_mem DUT
     (.clk(clk), .reset(reset), .req(req), .we(we), .byte_en(byte_en), .addr(addr),
      .wdata(wdata), .busy(busy), .done(done), .rdata(rdata), .ram_a(ram_a),
      .ram_we_n(ram_we_n), .ram_oe_n(ram_oe_n),
      .ram1_ce_n(ram1_ce_n), .ram1_ub_n(ram1_ub_n), .ram1_lb_n(ram1_lb_n),
      .ram1_dout(ram1_dout), .ram1_dout_en(ram1_dout_en), .ram1_din(ram1_din),
      .ram2_ce_n(ram2_ce_n), .ram2_ub_n(ram2_ub_n), .ram2_lb_n(ram2_lb_n),
      .ram2_dout(ram2_dout), .ram2_dout_en(ram2_dout_en), .ram2_din(ram2_din));

   ram_256kx16_model chip1
     (.a(ram_a), .dout(ram1_dout), .dout_en(ram1_dout_en), .ce_n(ram1_ce_n),
      .ub_n(ram1_ub_n), .lb_n(ram1_lb_n), .we_n(ram_we_n), .oe_n(ram_oe_n), .din(ram1_din));

   ram_256kx16_model chip2
     (.a(ram_a), .dout(ram2_dout), .dout_en(ram2_dout_en), .ce_n(ram2_ce_n),
      .ub_n(ram2_ub_n), .lb_n(ram2_lb_n), .we_n(ram_we_n), .oe_n(ram_oe_n), .din(ram2_din));

   function automatic logic [half-1:0] shadow_byte(input logic [mem_pkg::addr_bits-1:0] a);
      if (shadow.exists(a))
         return shadow[a];
      return '0;
   endfunction

   // the odd byte of a word sits on the upper lane.
   function automatic logic [mem_pkg::data_bits-1:0] expected_read
      (input logic is_byte, input logic [mem_pkg::addr_bits-1:0] a);
      if (is_byte)
         return {{half{1'b0}}, shadow_byte(a)};
      return {shadow_byte({a[mem_pkg::addr_bits-1:1], 1'b1}),
              shadow_byte({a[mem_pkg::addr_bits-1:1], 1'b0})};
   endfunction

   function automatic void write_shadow(input logic is_byte,
      input logic [mem_pkg::addr_bits-1:0] a, input logic [mem_pkg::data_bits-1:0] d);
      if (is_byte)
         shadow[a] = d[half-1:0];
      else
      begin
         shadow[{a[mem_pkg::addr_bits-1:1], 1'b0}] = d[half-1:0];
         shadow[{a[mem_pkg::addr_bits-1:1], 1'b1}] = d[mem_pkg::data_bits-1:half];
      end
   endfunction

   task automatic check_data(input string name, input logic [mem_pkg::data_bits-1:0] exp,
                             input logic [mem_pkg::data_bits-1:0] act);
      if (act === exp)
         pass_count++;
      else
      begin
         fail_count++;
         $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (act === exp)
         pass_count++;
      else
      begin
         fail_count++;
         $display("Fail %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic report_fault(input string msg);
      fail_count++;
      $display("%0t: %s", $time, msg);
   endtask

   // starts and ends on a falling edge.
   task automatic issue(input logic is_write, input logic is_byte,
      input logic [mem_pkg::addr_bits-1:0] a, input logic [mem_pkg::data_bits-1:0] d);
      while (busy)
         @(negedge clk);
      req = 1'b1;
      we = is_write;
      byte_en = is_byte;
      addr = a;
      wdata = d;
      pend_cycle.push_back(cycle_count);
      pend_read.push_back(!is_write);
      pend_exp.push_back(is_write ? '0 : expected_read(is_byte, a));
      if (is_write)
         write_shadow(is_byte, a, d);
      @(negedge clk);
      req = 1'b0;
   endtask

   task automatic finish_test(input string name);
      while (pend_cycle.size() != 0)
         @(negedge clk);
      $display("%s: %0d errors", name, fail_count - errors_before);
      errors_before = fail_count;
   endtask

   // one request is outstanding at most, so the queue head is the one in flight.
   initial
   begin : compare
      forever
      begin
         @(negedge clk);
         age = 0;
         if (pend_cycle.size() != 0)
            age = cycle_count - pend_cycle[0];
         if (done && pend_cycle.size() == 0)
            report_fault("done pulsed with no request outstanding");
         else if (done || age >= mem_pkg::seq_cycles)
         begin
            if (!done)
               report_fault($sformatf("no done pulse %0d cycles after req", age));
            else if (age != mem_pkg::seq_cycles)
               report_fault($sformatf("done came %0d cycles after req instead of %0d",
                                      age, mem_pkg::seq_cycles));
            else if (pend_read[0])
               check_data("rdata", pend_exp[0], rdata);
            check_level("busy", 1'b1, busy);
            void'(pend_cycle.pop_front());
            void'(pend_read.pop_front());
            void'(pend_exp.pop_front());
         end
         else if (age >= 1)
            check_level("busy", 1'b1, busy);
      end
   end

   initial
   begin
      void'($urandom(32'h6b7f));
      reset = 1'b1;
      req = 1'b0;
      we = 1'b0;
      byte_en = 1'b0;
      addr = '0;
      wdata = '0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_level("busy", 1'b0, busy);
      check_level("done", 1'b0, done);
      check_level("ram1_ce_n", 1'b1, ram1_ce_n);
      check_level("ram2_ce_n", 1'b1, ram2_ce_n);
      check_level("ram_we_n", 1'b1, ram_we_n);
      check_level("ram_oe_n", 1'b1, ram_oe_n);
      check_level("ram1_ub_n", 1'b1, ram1_ub_n);
      check_level("ram1_lb_n", 1'b1, ram1_lb_n);
      check_level("ram2_ub_n", 1'b1, ram2_ub_n);
      check_level("ram2_lb_n", 1'b1, ram2_lb_n);
      check_level("ram1_dout_en", 1'b0, ram1_dout_en);
      check_level("ram2_dout_en", 1'b0, ram2_dout_en);
      check_data("rdata", '0, rdata);
      finish_test("reset state");

      // all writes go out before any read so that aliased addresses show up.
      foreach (word_addrs[i])
      begin
         r = $urandom;
         issue(1'b1, 1'b0, word_addrs[i], r[mem_pkg::data_bits-1:0]);
      end
      foreach (word_addrs[i])
         issue(1'b0, 1'b0, word_addrs[i], '0);
      finish_test("word write and read");

      a0 = 20'h81234;
      issue(1'b1, 1'b0, a0, 16'h1111);
      issue(1'b1, 1'b1, a0, 16'hee5a);  // upper byte of wdata must not reach memory.
      issue(1'b0, 1'b0, a0, '0);
      issue(1'b1, 1'b1, {a0[mem_pkg::addr_bits-1:1], 1'b1}, 16'h77c3);
      issue(1'b0, 1'b0, a0, '0);
      issue(1'b0, 1'b1, a0, '0);
      issue(1'b0, 1'b1, {a0[mem_pkg::addr_bits-1:1], 1'b1}, '0);
      finish_test("byte merge and byte read");

      a0 = 20'h0c0de;
      issue(1'b1, 1'b0, a0, 16'h1234);
      issue(1'b1, 1'b0, a0 | 20'h80000, 16'habcd);
      issue(1'b0, 1'b0, a0, '0);
      issue(1'b0, 1'b0, a0 | 20'h80000, '0);
      finish_test("chip isolation");

      r = $urandom;
      base = {r[mem_pkg::addr_bits-1:4], 4'h0};  // a 16 byte window.
      repeat (300)
      begin
         r = $urandom;
         issue(r[31], r[30], base | {{(mem_pkg::addr_bits-4){1'b0}}, r[19:16]}, r[15:0]);
      end
      finish_test("random requests");

      $display("checks passed %0d, failed %0d", pass_count, fail_count);
      if (fail_count == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   initial
   begin
      repeat (timeout_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles before the tests ended", timeout_cycles);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* verification/ram_256kx16_model.sv */
`timescale 1ns/1ps
/*
 * Behavioral model of one asynchronous 256K x16 SRAM chip with split data pins.
 * Upper and lower bytes are kept in two byte arrays.
 */
module ram_256kx16_model
  (
   input  logic [mem_pkg::ram_addr_bits-1:0] a,
   input  logic [mem_pkg::data_bits-1:0]     dout,
   input  logic                             dout_en,
   input  logic                             ce_n,
   input  logic                             ub_n,
   input  logic                             lb_n,
   input  logic                             we_n,
   input  logic                             oe_n,
   output logic [mem_pkg::data_bits-1:0]     din
   );

   localparam int half = mem_pkg::data_bits / 2;

   logic [half-1:0] mem_hi [mem_pkg::chip_words];
   logic [half-1:0] mem_lo [mem_pkg::chip_words];

   initial
   begin
      for (int i = 0; i < mem_pkg::chip_words; i++)
      begin
         mem_hi[i] = '0;  // the chip powers up cleared.
         mem_lo[i] = '0;
      end
   end

   // a write completes on the rising edge of we_n.
   always @(posedge we_n)
   begin
      if (ce_n === 1'b0 && dout_en === 1'b1)
      begin
         if (!ub_n)
            mem_hi[a] = dout[mem_pkg::data_bits-1:half];
         if (!lb_n)
            mem_lo[a] = dout[half-1:0];
      end
   end

   assign din = (!ce_n && !oe_n) ? {mem_hi[a], mem_lo[a]} : '0;  // idle bus reads as zero.

endmodule

/* hw/s3board_mem.sv */
`timescale 1ns/1ps
/*
 * External memory controller for the two SRAM chips of the starter board.
 * Connects the sequencer, the pin stage and the byte lane steering.
 */
module s3board_mem
  (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             req,
   input  logic                             we,
   input  logic                             byte_en,
   input  logic [mem_pkg::addr_bits-1:0]     addr,
   input  logic [mem_pkg::data_bits-1:0]     wdata,
   output logic                             busy,
   output logic                             done,
   output logic [mem_pkg::data_bits-1:0]     rdata,
   output logic [mem_pkg::ram_addr_bits-1:0] ram_a,
   output logic                             ram_we_n,
   output logic                             ram_oe_n,
   output logic                             ram1_ce_n,
   output logic                             ram1_ub_n,
   output logic                             ram1_lb_n,
   output logic [mem_pkg::data_bits-1:0]     ram1_dout,
   output logic                             ram1_dout_en,
   input  logic [mem_pkg::data_bits-1:0]     ram1_din,
   output logic                             ram2_ce_n,
   output logic                             ram2_ub_n,
   output logic                             ram2_lb_n,
   output logic [mem_pkg::data_bits-1:0]     ram2_dout,
   output logic                             ram2_dout_en,
   input  logic [mem_pkg::data_bits-1:0]     ram2_din
   );

   logic                          load;
   logic                          cs_on;
   logic                          wr_on;
   logic                          rd_on;
   logic                          capture;
   logic [mem_pkg::data_bits-1:0] lane_wdata;
   logic                          lane_ub_n;
   logic                          lane_lb_n;
   logic [mem_pkg::data_bits-1:0] rd_word;
   logic                          hold_lsb;

   sram_seq u_seq
     (.clk(clk), .reset(reset), .req(req), .we(we), .busy(busy), .done(done),
      .load(load), .cs_on(cs_on), .wr_on(wr_on), .rd_on(rd_on), .capture(capture));

   sram_pins u_pins
     (.clk(clk), .reset(reset), .load(load), .cs_on(cs_on), .wr_on(wr_on),
      .rd_on(rd_on), .capture(capture), .addr(addr), .lane_wdata(lane_wdata),
      .lane_ub_n(lane_ub_n), .lane_lb_n(lane_lb_n),
      .ram1_din(ram1_din), .ram2_din(ram2_din),
      .ram_a(ram_a), .ram_we_n(ram_we_n), .ram_oe_n(ram_oe_n),
      .ram1_ce_n(ram1_ce_n), .ram1_ub_n(ram1_ub_n), .ram1_lb_n(ram1_lb_n),
      .ram1_dout(ram1_dout), .ram1_dout_en(ram1_dout_en),
      .ram2_ce_n(ram2_ce_n), .ram2_ub_n(ram2_ub_n), .ram2_lb_n(ram2_lb_n),
      .ram2_dout(ram2_dout), .ram2_dout_en(ram2_dout_en),
      .rd_word(rd_word), .addr_lsb(hold_lsb));

   // write steering uses the live bus bit, read alignment the held one.
   byte_lane u_lane
     (.byte_en(byte_en), .addr_lsb(addr[0]), .wdata(wdata), .rd_word(rd_word),
      .rd_lsb(hold_lsb), .lane_wdata(lane_wdata), .lane_ub_n(lane_ub_n),
      .lane_lb_n(lane_lb_n), .rdata(rdata));

endmodule

/* hw/sram_pins.sv */
`timescale 1ns/1ps
/*
 * Registered pin stage for the two board SRAM chips.
 * Chip select decode, byte enables, write strobe, data drive and read capture.
 */
module sram_pins
  (
   input  logic                             clk,
   input  logic                             reset,
   input  logic                             load,
   input  logic                             cs_on,
   input  logic                             wr_on,
   input  logic                             rd_on,
   input  logic                             capture,
   input  logic [mem_pkg::addr_bits-1:0]     addr,
   input  logic [mem_pkg::data_bits-1:0]     lane_wdata,
   input  logic                             lane_ub_n,
   input  logic                             lane_lb_n,
   input  logic [mem_pkg::data_bits-1:0]     ram1_din,
   input  logic [mem_pkg::data_bits-1:0]     ram2_din,
   output logic [mem_pkg::ram_addr_bits-1:0] ram_a,
   output logic                             ram_we_n,
   output logic                             ram_oe_n,
   output logic                             ram1_ce_n,
   output logic                             ram1_ub_n,
   output logic                             ram1_lb_n,
   output logic [mem_pkg::data_bits-1:0]     ram1_dout,
   output logic                             ram1_dout_en,
   output logic                             ram2_ce_n,
   output logic                             ram2_ub_n,
   output logic                             ram2_lb_n,
   output logic [mem_pkg::data_bits-1:0]     ram2_dout,
   output logic                             ram2_dout_en,
   output logic [mem_pkg::data_bits-1:0]     rd_word,
   output logic                             addr_lsb
   );

   localparam int half = mem_pkg::data_bits / 2;

   logic [mem_pkg::data_bits-1:0] dout_q;
   logic                          chip_q;
   logic                          ub_q;
   logic                          lb_q;
   logic                          chip_nx;
   logic                          ub_nx;
   logic                          lb_nx;
   logic                          drive_q;
   logic [mem_pkg::data_bits-1:0] din_sel;

   assign chip_nx = load ? addr[mem_pkg::addr_bits-1] : chip_q;  // bit 19 picks the chip.
   assign ub_nx   = load ? lane_ub_n : ub_q;
   assign lb_nx   = load ? lane_lb_n : lb_q;
   assign drive_q = ram1_dout_en || ram2_dout_en;
   assign din_sel = chip_q ? ram2_din : ram1_din;

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         ram_a  <= addr[mem_pkg::ram_addr_bits:1];
         dout_q <= lane_wdata;
         chip_q <= addr[mem_pkg::addr_bits-1];
         ub_q   <= lane_ub_n;
         lb_q   <= lane_lb_n;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ram1_ce_n    <= 1'b1;
         ram2_ce_n    <= 1'b1;
         ram1_ub_n    <= 1'b1;
         ram1_lb_n    <= 1'b1;
         ram2_ub_n    <= 1'b1;
         ram2_lb_n    <= 1'b1;
         ram1_dout_en <= 1'b0;
         ram2_dout_en <= 1'b0;
         ram_we_n     <= 1'b1;
         ram_oe_n     <= 1'b1;
         rd_word      <= '0;
         addr_lsb     <= 1'b0;
      end
      else
      begin
         ram1_ce_n    <= !(cs_on && !chip_nx);
         ram2_ce_n    <= !(cs_on && chip_nx);
         ram1_ub_n    <= !(cs_on && !chip_nx && !ub_nx);
         ram1_lb_n    <= !(cs_on && !chip_nx && !lb_nx);
         ram2_ub_n    <= !(cs_on && chip_nx && !ub_nx);
         ram2_lb_n    <= !(cs_on && chip_nx && !lb_nx);
         ram1_dout_en <= wr_on && !chip_nx;
         ram2_dout_en <= wr_on && chip_nx;
         ram_oe_n     <= !rd_on;
         // we_n falls the cycle after the data bus is driven and rises one cycle later.
         ram_we_n     <= !(wr_on && drive_q && ram_we_n);
         if (capture)
         begin
            rd_word  <= {ub_q ? {half{1'b0}} : din_sel[mem_pkg::data_bits-1:half],
                         lb_q ? {half{1'b0}} : din_sel[half-1:0]};  // unused lane reads zero.
            addr_lsb <= lb_q && !ub_q;  // upper byte alone means an odd byte read.
         end
      end
   end

   assign ram1_dout = dout_q;
   assign ram2_dout = dout_q;

   a_one_chip: assert property (@(posedge clk) disable iff (reset)
      !(!ram1_ce_n && !ram2_ce_n))
      else $error("both chip enables low.");

endmodule

/* hw/sram_seq.sv */
`timescale 1ns/1ps
/*
 * Request sequencer for the asynchronous SRAM pins.
 * Steps each accepted request through setup, strobe and finish and issues
 * the per-cycle controls for the pin stage, plus busy and done.
 */
module sram_seq
  (
   input  logic clk,
   input  logic reset,
   input  logic req,
   input  logic we,
   output logic busy,
   output logic done,
   output logic load,
   output logic cs_on,
   output logic wr_on,
   output logic rd_on,
   output logic capture
   );

   typedef enum logic [1:0]
   {
      idle   = 2'd0,
      setup  = 2'd1,
      strobe = 2'd2,
      finish = 2'd3
   } state_t;

   state_t state;
   state_t state_nx;
   logic   we_q;
   logic   accept;
   logic   active;

   assign accept = (state == idle) && req;                  // req is only taken when idle.
   assign active = (state == setup) || (state == strobe);

   always_comb
   begin
      state_nx = state;
      case (state)
         idle:
            if (req)
               state_nx = setup;
         setup:
            state_nx = strobe;
         strobe:
            state_nx = finish;
         finish:
            state_nx = idle;
         default:
            state_nx = idle;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= idle;
      else
         state <= state_nx;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         we_q <= we;  // direction of the request in flight.
   end

   // The pin stage registers these, so each one is raised a cycle
   // before it should show on the pins.
   assign load    = accept;
   assign cs_on   = accept || active;                       // chip enabled in cycles 1 to 3.
   assign wr_on   = (accept && we) || (active && we_q);     // data driven in cycles 1 to 3.
   assign rd_on   = (accept && !we) || ((state == setup) && !we_q);
   assign capture = (state == strobe) && !we_q;             // din sampled at the end of cycle 2.

   assign busy = (state != idle);
   assign done = (state == finish);

   a_req_not_busy: assert property (@(posedge clk) disable iff (reset)
      !(req && busy))
      else $error("req raised while busy.");

   // the request latency seen on the bus is fixed.
   a_done_latency: assert property (@(posedge clk) disable iff (reset)
      (req && !busy) |-> (!done) [*mem_pkg::seq_cycles] ##1 done)
      else $error("done not seq_cycles after an accepted req.");

   a_dir_onehot: assert property (@(posedge clk) disable iff (reset)
      !(wr_on && rd_on))
      else $error("read and write strobes overlap.");

endmodule

/* hw/byte_lane.sv */
`timescale 1ns/1ps
/*
 * Byte lane steering between the processor bus and the 16-bit chip lanes.
 * Builds lane write data and active-low byte enables, and aligns read data.
 */
module byte_lane
  (
   input  logic                         byte_en,
   input  logic                         addr_lsb,
   input  logic [mem_pkg::data_bits-1:0] wdata,
   input  logic [mem_pkg::data_bits-1:0] rd_word,
   input  logic                         rd_lsb,
   output logic [mem_pkg::data_bits-1:0] lane_wdata,
   output logic                         lane_ub_n,
   output logic                         lane_lb_n,
   output logic [mem_pkg::data_bits-1:0] rdata
   );

   localparam int half = mem_pkg::data_bits / 2;

   always_comb
   begin
      if (byte_en)
      begin
         lane_wdata = {wdata[half-1:0], wdata[half-1:0]};  // same byte on both lanes.
         lane_ub_n  = ~addr_lsb;                             // odd byte is the upper lane.
         lane_lb_n  = addr_lsb;
      end
      else
      begin
         lane_wdata = wdata;
         lane_ub_n  = 1'b0;  // word access ignores bit 0.
         lane_lb_n  = 1'b0;
      end
   end

   // The pin stage zeroes the lanes that were not enabled when it captures.
   // rd_lsb is high only for a byte read of the upper lane, which must be
   // shifted down; lower byte and word reads pass as captured.
   always_comb
   begin
      if (rd_lsb)
         rdata = {{half{1'b0}}, rd_word[mem_pkg::data_bits-1:half]};
      else
         rdata = rd_word;
   end

endmodule

/* hw/mem_pkg.sv */
/*
 * Geometry and timing constants for the board SRAM subsystem:
 * bus and chip address widths, data width, chip depth and request latency.
 */
package mem_pkg;

   // bus byte address layout is {chip, word[17:0], byte}.
   localparam int addr_bits = 20;

   localparam int ram_addr_bits = 18;  // address pins of one chip.

   localparam int data_bits = 16;  // chip data bus and bus data are the same width.

   localparam int chip_words = 262144;  // words in one 256K x16 chip.

   // clock edges from an accepted request to its done pulse.
   // reads and writes take the same time.
   localparam int seq_cycles = 3;

endpackage
